/* bench/cpu_asserts.sv */
////////////////////////////////////////
// Handshake, output pulse and halt checks
////////////////////////////////////////

`timescale 1ns/100ps

module cpu_asserts (
    input logic clk,
    input logic rst,
    input logic prog_req,
    input logic prog_ack,
    input logic out_valid,
    input logic halted
);

    int fail_count = 0;  // Polled by the testbench

    // Ack answers a pending request only, req seen on the edge that raised ack
    ack_rise_a: assert property (@(posedge clk) disable iff (rst)
        $rose(prog_ack) |-> $past(prog_req))
        else begin
            $error("prog_ack rose while prog_req was low");
            fail_count++;
        end

    // Phase 4 follows phase 3
    ack_fall_a: assert property (@(posedge clk) disable iff (rst)
        $fell(prog_ack) |-> !$past(prog_req))
        else begin
            $error("prog_ack fell while prog_req was high");
            fail_count++;
        end

    pulse_a: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid lasted two cycles");
            fail_count++;
        end

    // Sticky until reset
    halt_hold_a: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
        else begin
            $error("halted fell outside reset");
            fail_count++;
        end

    quiet_a: assert property (@(posedge clk) disable iff (rst)
        halted |-> !out_valid)
        else begin
            $error("out_valid seen after halt");
            fail_count++;
        end

endmodule

bind control_sequencer cpu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .prog_req  (prog_req),
    .prog_ack  (prog_ack),
    .out_valid (out_valid),
    .halted    (halted)
);

/* bench/cpu_tb.sv */
////////////////////////////////////////
// CPU testbench, host loader, ISA model
////////////////////////////////////////

`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int WAIT_LIMIT = 40;    // Cycles allowed per handshake phase
    localparam int RUN_LIMIT  = 2000;  // Cycles allowed until HLT

    logic                   clk;
    logic                   rst;
    logic                   prog_mode;
    logic                   prog_req;
    logic [`CPU_DATA_W-1:0] prog_data;
    logic                   prog_ack;
    logic [`CPU_DATA_W-1:0] out_value;
    logic                   out_valid;
    logic                   halted;

    logic [`CPU_DATA_W-1:0] image [`CPU_RAM_DEPTH];  // Program under test
    logic [`CPU_DATA_W-1:0] exp_q [$];               // Expected OUT values, in order
    integer                 seed;
    logic [`CPU_DATA_W-1:0] x;
    logic [`CPU_DATA_W-1:0] y;
    logic [`CPU_DATA_W-1:0] w;

    cpu_top uut (
        .clk       (clk),
        .rst       (rst),
        .prog_mode (prog_mode),
        .prog_req  (prog_req),
        .prog_data (prog_data),
        .prog_ack  (prog_ack),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [`CPU_DATA_W-1:0] actual,
                               input logic [`CPU_DATA_W-1:0] expected);
        assert (actual === expected) else
            report_failure($sformatf("ERROR time=%0t %s expected=%02h actual=%02h",
                                     $time, name, expected, actual));
    endtask

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (uut.u_seq.u_asserts.fail_count != 0) begin
            report_failure("A concurrent assertion on the sequencer failed");
        end
    end

    function automatic int host_delay();
        return $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
    endfunction

    // One byte through the four-phase handshake
    task automatic send_byte(input logic [`CPU_DATA_W-1:0] data);
        int n;
        repeat (host_delay()) @(negedge clk);
        prog_data = data;
        prog_req  = 1'b1;
        n = 0;
        while (!prog_ack) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_failure("prog_ack never rose after prog_req went high");
        end
        repeat (host_delay()) @(negedge clk);  // Host back-pressure
        prog_req = 1'b0;
        n = 0;
        while (prog_ack) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_failure("prog_ack stayed high after prog_req dropped");
        end
    endtask

    // Reference ISA, fills exp_q from the image
    task automatic run_model();
        logic [`CPU_DATA_W-1:0] mem [`CPU_RAM_DEPTH];
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] arg;
        logic [`CPU_DATA_W-1:0] ir;
        logic [`CPU_DATA_W:0]   wide;
        logic [`CPU_ADDR_W-1:0] pc;
        logic                   c;
        logic                   z;
        int                     steps;
        bit                     done;
        mem = image;
        a = '0;
        pc = '0;
        c = 1'b0;   // Flags start cleared
        z = 1'b0;
        steps = 0;
        done = 1'b0;
        exp_q.delete();
        while (!done && steps < 500) begin
            ir  = mem[pc];
            arg = mem[ir[3:0]];
            pc  = pc + 1'b1;
            steps++;
            case (ir[7:4])
                OP_LDA: a = arg;
                OP_ADD: begin
                    wide = {1'b0, a} + {1'b0, arg};
                    a = wide[7:0];
                    c = wide[8];         // Carry out of bit 7
                    z = (a == '0);
                end
                OP_SUB: begin
                    c = (a >= arg);      // No borrow
                    a = a - arg;
                    z = (a == '0);
                end
                OP_STA: mem[ir[3:0]] = a;
                OP_LDI: a = {4'h0, ir[3:0]};
                OP_JMP: pc = ir[3:0];
                OP_JC:  if (c) pc = ir[3:0];
                OP_JZ:  if (z) pc = ir[3:0];
                OP_OUT: exp_q.push_back(a);
                OP_HLT: done = 1'b1;
                default: ;               // NOP and unused codes
            endcase
        end
        if (!done) report_failure("Model program never reached HLT");
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst       = 1'b1;
        prog_mode = 1'b1;
        prog_req  = 1'b0;
        repeat (10) @(negedge clk);
        check_value("halted", halted, 1'b0);
        check_value("out_valid", out_valid, 1'b0);
        check_value("prog_ack", prog_ack, 1'b0);
        check_value("out_value", out_value, '0);
        rst = 1'b0;
    endtask

    // Checks each OUT, returns early after stop_after outputs when nonzero
    task automatic run_program(input int stop_after);
        int                     n;
        int                     seen;
        logic [`CPU_DATA_W-1:0] expected_out;
        n = 0;
        seen = 0;
        while (!halted) begin
            @(negedge clk);
            n++;
            if (n > RUN_LIMIT) report_failure("CPU did not halt within the run limit");
            if (out_valid) begin
                if (exp_q.size() == 0) report_failure("out_valid pulsed with no output expected");
                expected_out = exp_q.pop_front();
                check_value("out_value", out_value, expected_out);
                seen++;
                if (stop_after != 0 && seen == stop_after) return;
            end
        end
        if (exp_q.size() != 0) report_failure("CPU halted before all expected outputs");
        repeat (50) begin                        // Quiet after halt
            @(negedge clk);
            check_value("out_valid", out_valid, 1'b0);
            check_value("halted", halted, 1'b1);
        end
    endtask

    task automatic load_and_run(input int stop_after);
        apply_reset();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            send_byte(image[i]);
        end
        run_model();
        prog_mode = 1'b0;  // Run from address 0
        run_program(stop_after);
    endtask

    initial begin
        rst       = 1'b1;
        prog_mode = 1'b1;
        prog_req  = 1'b0;
        prog_data = '0;
        seed      = 32'ha42e5c4f;

        // Arithmetic, wrap-around on random data
        x = $random(seed);
        y = $random(seed);
        w = $random(seed);
        image = '{{OP_LDA, 4'd13}, {OP_ADD, 4'd14}, {OP_OUT, 4'd0}, {OP_SUB, 4'd15},
                  {OP_OUT, 4'd0}, {OP_ADD, 4'd14}, {OP_OUT, 4'd0}, {OP_HLT, 4'd0},
                  8'h00, 8'h00, 8'h00, 8'h00, 8'h00, x, y, w};
        load_and_run(0);

        // Memory round trip through spare addresses
        x = $random(seed);
        image = '{{OP_LDI, 4'd9}, {OP_STA, 4'd12}, {OP_LDI, 4'd0}, {OP_LDA, 4'd12},
                  {OP_OUT, 4'd0}, {OP_LDA, 4'd13}, {OP_STA, 4'd11}, {OP_LDI, 4'd3},
                  {OP_LDA, 4'd11}, {OP_OUT, 4'd0}, {OP_HLT, 4'd0}, 8'h00,
                  8'h00, x, 8'h00, 8'h00};
        load_and_run(0);

        // JZ then JC, markers 1 borrow, 2 zero, 3 no borrow
        for (int k = 0; k < 3; k++) begin
            w = $random(seed) | 8'h01;
            case (k)
                0: begin         // A above B
                    x = w;
                    y = w >> 1;
                end
                1: begin         // A below B
                    x = w >> 1;
                    y = w;
                end
                default: begin
                    x = w;
                    y = w;
                end
            endcase
            image = '{{OP_LDA, 4'd14}, {OP_SUB, 4'd15}, {OP_JZ, 4'd6}, {OP_JC, 4'd8},
                      {OP_LDI, 4'd1}, {OP_JMP, 4'd9}, {OP_LDI, 4'd2}, {OP_JMP, 4'd9},
                      {OP_LDI, 4'd3}, {OP_OUT, 4'd0}, {OP_HLT, 4'd0}, 8'h00,
                      8'h00, 8'h00, x, y};
            load_and_run(0);
        end

        // Countdown loop, JMP back until zero
        w = 8'd2 + ($unsigned($random(seed)) % 4);
        image = '{{OP_LDA, 4'd13}, {OP_SUB, 4'd14}, {OP_STA, 4'd13}, {OP_OUT, 4'd0},
                  {OP_JZ, 4'd6}, {OP_JMP, 4'd0}, {OP_HLT, 4'd0}, 8'h00,
                  8'h00, 8'h00, 8'h00, 8'h00, 8'h00, w, 8'h01, 8'h00};
        load_and_run(0);

        // Reset mid-run, then reload and full rerun
        load_and_run(1);
        load_and_run(0);

        if (uut.u_seq.u_asserts.fail_count != 0) begin
            $display("RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* hdl/alu.sv */
////////////////////////////////////////
// Adder/subtractor with carry and zero flags
////////////////////////////////////////

`timescale 1ns/100ps

`include "cpu_settings.svh"

module alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  logic                  sub,         // 1 selects A-B
    input  logic                  flags_load,
    output logic [`CPU_DATA_W-1:0] result,
    output logic                  carry,
    output logic                  zero
);

    logic [`CPU_DATA_W-1:0] b_eff;
    logic [`CPU_DATA_W:0]   sum;  // One extra bit for the carry out

    // Two's complement subtract, carry out means no borrow
    assign b_eff  = sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, sub};
    assign result = sum[`CPU_DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_load) begin
            carry <= sum[`CPU_DATA_W];
            zero  <= (result == '0);
        end
    end

endmodule

/* hdl/control_sequencer.sv */
////////////////////////////////////////
// Load handshake and fetch/execute FSM
////////////////////////////////////////

`timescale 1ns/100ps

module control_sequencer import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,        // Synchronous, active high
    input  logic       prog_mode,  // High while the host loads RAM
    input  logic       prog_req,
    output logic       prog_ack,
    output logic       halted,
    output logic       out_valid,
    cpu_ctrl_if.seq    cif
);

    seq_state_t state;
    seq_state_t state_next;
    ctrl_word_t cw;

    assign cif.ctrl = cw;

    // Next state and control word
    always_comb begin
        cw         = '0;
        state_next = state;
        case (state)
            S_LOAD_IDLE: begin
                if (!prog_mode) begin
                    cw.pc_clear = 1'b1;        // Run starts at address 0
                    state_next  = S_FETCH_ADDR;
                end else begin
                    // PC doubles as the load address counter
                    cw.bus_src  = SRC_PC;
                    cw.mar_load = 1'b1;
                    if (prog_req) begin
                        state_next = S_LOAD_WRITE;
                    end
                end
            end
            S_LOAD_WRITE: begin
                cw.bus_src   = SRC_HOST;       // MAR already holds the load address
                cw.ram_write = 1'b1;
                state_next   = S_LOAD_ACK;
            end
            S_LOAD_ACK: begin
                if (!prog_req) begin           // Phase 4, next address
                    cw.pc_inc  = 1'b1;         // Wraps after 16 bytes
                    state_next = S_LOAD_IDLE;
                end
            end
            S_FETCH_ADDR: begin
                cw.bus_src  = SRC_PC;
                cw.mar_load = 1'b1;
                state_next  = S_FETCH_READ;
            end
            S_FETCH_READ: begin
                cw.bus_src = SRC_RAM;
                cw.ir_load = 1'b1;
                cw.pc_inc  = 1'b1;
                state_next = S_EXEC1;
            end
            S_EXEC1: begin
                state_next = S_EXEC2;
                case (cif.opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        cw.bus_src  = SRC_IR_OPERAND;  // Operand is a RAM address
                        cw.mar_load = 1'b1;
                    end
                    OP_LDI: begin
                        cw.bus_src = SRC_IR_OPERAND;
                        cw.a_load  = 1'b1;
                    end
                    OP_JMP: begin
                        cw.bus_src = SRC_IR_OPERAND;
                        cw.pc_load = 1'b1;
                    end
                    OP_JC: begin
                        cw.bus_src = SRC_IR_OPERAND;
                        cw.pc_load = cif.carry;
                    end
                    OP_JZ: begin
                        cw.bus_src = SRC_IR_OPERAND;
                        cw.pc_load = cif.zero;
                    end
                    OP_OUT: begin
                        cw.bus_src  = SRC_A;
                        cw.out_load = 1'b1;
                    end
                    OP_HLT: state_next = S_HALT;
                    default: ;                 // NOP and unused codes
                endcase
            end
            S_EXEC2: begin
                state_next = S_EXEC3;
                case (cif.opcode)
                    OP_LDA: begin
                        cw.bus_src = SRC_RAM;
                        cw.a_load  = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        cw.bus_src = SRC_RAM;  // Second operand into B
                        cw.b_load  = 1'b1;
                    end
                    OP_STA: begin
                        cw.bus_src   = SRC_A;
                        cw.ram_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            S_EXEC3: begin
                state_next = S_FETCH_ADDR;
                if (cif.opcode == OP_ADD || cif.opcode == OP_SUB) begin
                    cw.bus_src    = SRC_ALU;
                    cw.alu_sub    = (cif.opcode == OP_SUB);
                    cw.a_load     = 1'b1;
                    cw.flags_load = 1'b1;
                end
            end
            S_HALT:  state_next = S_HALT;      // Left only through reset
            default: state_next = S_LOAD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_LOAD_IDLE;
            prog_ack  <= 1'b0;
            halted    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            prog_ack  <= (state_next == S_LOAD_ACK);  // High for the whole ACK state
            halted    <= (state_next == S_HALT);
            out_valid <= (state == S_EXEC1) && (cif.opcode == OP_OUT); // Same edge as out reg
        end
    end

endmodule

/* hdl/cpu_ctrl_if.sv */
////////////////////////////////////////
// Control and status link, sequencer to datapath
////////////////////////////////////////

`timescale 1ns/100ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    // Control word for the current cycle
    ctrl_word_t ctrl;

    // Decoded from the instruction register
    opcode_t opcode;

    // Registered ALU flags, only ADD and SUB move them
    logic carry;   // Carry out, or no borrow on SUB
    logic zero;    // Last ALU result was zero

    // Sequencer side
    modport seq (
        output ctrl,
        input  opcode,
        input  carry,
        input  zero
    );

    // Datapath side
    modport dp (
        input  ctrl,
        output opcode,
        output carry,
        output zero
    );

endinterface

/* hdl/cpu_pkg.sv */
////////////////////////////////////////
// Opcodes, sequencer states, control word
////////////////////////////////////////

package cpu_pkg;

    // Upper nibble of an instruction byte
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDA = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_STA = 4'd4,
        OP_LDI = 4'd5,
        OP_JMP = 4'd6,
        OP_JC  = 4'd7,
        OP_JZ  = 4'd8,
        OP_OUT = 4'd14,
        OP_HLT = 4'd15
    } opcode_t;   // Other codes fall through as NOP

    typedef enum logic [3:0] {
        S_LOAD_IDLE,   // Waiting for a host byte or for run
        S_LOAD_WRITE,  // Host byte goes into RAM
        S_LOAD_ACK,    // Ack held until req drops
        S_FETCH_ADDR,
        S_FETCH_READ,
        S_EXEC1,
        S_EXEC2,
        S_EXEC3,
        S_HALT
    } seq_state_t;

    // Single driver of the internal bus
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_PC,
        SRC_RAM,
        SRC_IR_OPERAND,
        SRC_A,
        SRC_ALU,
        SRC_HOST
    } bus_src_t;

    typedef struct packed {
        bus_src_t bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     alu_sub;     // Subtract instead of add
        logic     flags_load;
        logic     out_load;
        logic     pc_clear;
    } ctrl_word_t;

endpackage

/* hdl/cpu_settings.svh */
////////////////////////////////////////
// Width and depth macros for the CPU
////////////////////////////////////////

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Bus and register width
`define CPU_DATA_W 8

// Operand and address width, lower nibble of an instruction
`define CPU_ADDR_W 4

// Number of RAM bytes
`define CPU_RAM_DEPTH 16

`endif

/* hdl/cpu_top.sv */
////////////////////////////////////////
// CPU top, sequencer plus datapath
////////////////////////////////////////

`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,        // Synchronous, active high
    input  logic                   prog_mode,  // High to load, low to run
    input  logic                   prog_req,   // Host byte ready
    input  logic [`CPU_DATA_W-1:0] prog_data,
    output logic                   prog_ack,   // Byte taken
    output logic [`CPU_DATA_W-1:0] out_value,
    output logic                   out_valid,  // One cycle per OUT
    output logic                   halted      // Sticky until reset
);

    // Control word down, opcode and flags up
    cpu_ctrl_if cif ();

    control_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .prog_mode (prog_mode),
        .prog_req  (prog_req),
        .prog_ack  (prog_ack),
        .halted    (halted),
        .out_valid (out_valid),
        .cif       (cif.seq)
    );

    datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .prog_data (prog_data),
        .out_value (out_value),
        .cif       (cif.dp)
    );

endmodule

/* hdl/datapath.sv */
////////////////////////////////////////
// Registers, RAM, ALU and bus multiplexer
////////////////////////////////////////

`timescale 1ns/100ps

`include "cpu_settings.svh"

module datapath import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_DATA_W-1:0] prog_data,  // Host byte during loading
    output logic [`CPU_DATA_W-1:0] out_value,
    cpu_ctrl_if.dp                 cif
);

    localparam int PAD_W = `CPU_DATA_W - `CPU_ADDR_W;  // Zero fill for nibble sources

    logic [`CPU_ADDR_W-1:0] pc_q;
    logic [`CPU_ADDR_W-1:0] mar_q;
    logic [`CPU_DATA_W-1:0] ram_q [`CPU_RAM_DEPTH];
    logic [`CPU_DATA_W-1:0] ir_q;
    logic [`CPU_DATA_W-1:0] a_q;
    logic [`CPU_DATA_W-1:0] b_q;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] ram_rd;
    logic [`CPU_DATA_W-1:0] bus;

    assign ram_rd     = ram_q[mar_q];                     // Asynchronous read
    assign cif.opcode = opcode_t'(ir_q[`CPU_DATA_W-1:`CPU_ADDR_W]);

    // One-driver bus
    always_comb begin
        case (cif.ctrl.bus_src)
            SRC_PC:         bus = {{PAD_W{1'b0}}, pc_q};
            SRC_RAM:        bus = ram_rd;
            SRC_IR_OPERAND: bus = {{PAD_W{1'b0}}, ir_q[`CPU_ADDR_W-1:0]};
            SRC_A:          bus = a_q;
            SRC_ALU:        bus = alu_result;
            SRC_HOST:       bus = prog_data;
            default:        bus = '0;                     // Idle bus reads as zero
        endcase
    end

    // Program counter, also the load address while programming
    always_ff @(posedge clk) begin
        if (rst || cif.ctrl.pc_clear) begin
            pc_q <= '0;
        end else if (cif.ctrl.pc_load) begin
            pc_q <= bus[`CPU_ADDR_W-1:0];                 // Jump target
        end else if (cif.ctrl.pc_inc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mar_q <= '0;
        end else if (cif.ctrl.mar_load) begin
            mar_q <= bus[`CPU_ADDR_W-1:0];
        end
    end

    // Program and data RAM
    always_ff @(posedge clk) begin
        if (cif.ctrl.ram_write) begin
            ram_q[mar_q] <= bus;
        end
    end

    // Instruction register, opcode in the upper nibble
    always_ff @(posedge clk) begin
        if (rst) begin
            ir_q <= '0;
        end else if (cif.ctrl.ir_load) begin
            ir_q <= bus;
        end
    end

    // Accumulator and B operand
    always_ff @(posedge clk) begin
        if (cif.ctrl.a_load) begin
            a_q <= bus;
        end
        if (cif.ctrl.b_load) begin
            b_q <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_value <= '0;
        end else if (cif.ctrl.out_load) begin
            out_value <= bus;                             // Holds until the next OUT
        end
    end

    alu u_alu (
        .clk        (clk),
        .rst        (rst),
        .a          (a_q),
        .b          (b_q),
        .sub        (cif.ctrl.alu_sub),
        .flags_load (cif.ctrl.flags_load),
        .result     (alu_result),
        .carry      (cif.carry),
        .zero       (cif.zero)
    );

endmodule

/* list.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_ctrl_if.sv
hdl/alu.sv
hdl/datapath.sv
hdl/control_sequencer.sv
hdl/cpu_top.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv
